// File: hdl/skip_pq_pkg.sv
`default_nettype none

package skip_pq_pkg;

	// Payload widths
	localparam int RANK_WIDTH = 10;
	localparam int META_WIDTH = 20;

	typedef logic [RANK_WIDTH-1:0] rank_t;
	typedef logic [META_WIDTH-1:0] meta_t;

	// Sentinel ranks, head holds the largest and tail the smallest
	localparam rank_t RANK_MAX = '1;
	localparam rank_t RANK_MIN = '0;

	// 32 nodes in the node memories, two of them sentinels
	localparam int DEF_L2_NODES = 5;

	// Front register depth
	localparam int DEF_OUT_DEPTH = 4;

endpackage

`default_nettype wire

// File: hdl/node_ram.sv
`default_nettype none

module node_ram #(
	parameter type T = logic,
	parameter int L2_DEPTH = 5
) (
	input wire logic clk,
	input wire logic wr_en,
	input wire logic [L2_DEPTH-1:0] wr_addr,
	input wire T wr_data,
	input wire logic [L2_DEPTH-1:0] rd_addr,
	output T rd_data
);

	T mem [2 ** L2_DEPTH];

	// One write port, one read port with a single cycle of latency
	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			mem[wr_addr] <= wr_data;
		end
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// File: hdl/free_list.sv
`default_nettype none

module free_list #(
	parameter int L2_NODES = 5
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic push,
	input wire logic pop,
	input wire logic [L2_NODES-1:0] push_node,
	output logic [L2_NODES-1:0] head_node,
	output logic empty
);

	localparam int DEPTH = 2 ** L2_NODES;

	logic [L2_NODES-1:0] fifo_mem [DEPTH];
	logic [L2_NODES-1:0] rd_ptr;
	logic [L2_NODES-1:0] wr_ptr;
	logic [L2_NODES:0] fill;
	logic do_push;
	logic do_pop;

	assign do_push = push && (fill != (L2_NODES + 1)'(DEPTH));
	assign do_pop = pop && !empty;

	always_ff @(posedge clk)
	begin
		if (do_push)
		begin
			fifo_mem[wr_ptr] <= push_node;
		end
	end

	// Pointers wrap on their own width
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			fill <= '0;
		end
		else
		begin
			if (do_push)
			begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop)
			begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			fill <= fill + do_push - do_pop;
		end
	end

	// Fall-through, the oldest free node is always at the output
	assign head_node = fifo_mem[rd_ptr];
	assign empty = (fill == '0);

endmodule

`default_nettype wire

// File: hdl/sorted_out_reg.sv
`default_nettype none

module sorted_out_reg #(
	parameter int L2_NODES = skip_pq_pkg::DEF_L2_NODES,
	parameter int OUT_DEPTH = skip_pq_pkg::DEF_OUT_DEPTH
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic insert,
	input wire logic remove,
	input wire logic busy,
	input wire logic list_empty,
	input wire skip_pq_pkg::rank_t rank_in,
	input wire skip_pq_pkg::meta_t meta_in,
	input wire logic deq_valid,
	input wire skip_pq_pkg::rank_t deq_rank,
	input wire skip_pq_pkg::meta_t deq_meta,
	output skip_pq_pkg::rank_t rank_out,
	output skip_pq_pkg::meta_t meta_out,
	output logic valid_out,
	output logic has_room,
	output logic push_valid,
	output skip_pq_pkg::rank_t push_rank,
	output skip_pq_pkg::meta_t push_meta,
	output logic [L2_NODES:0] num_entries
);

	localparam int CAPACITY = 2 ** L2_NODES - 2 + OUT_DEPTH;
	localparam int NW = L2_NODES + 1;
	localparam int CW = $clog2(OUT_DEPTH + 1);

	skip_pq_pkg::rank_t rank_q [OUT_DEPTH];
	skip_pq_pkg::meta_t meta_q [OUT_DEPTH];
	skip_pq_pkg::rank_t pop_rank [OUT_DEPTH];
	skip_pq_pkg::meta_t pop_meta [OUT_DEPTH];
	skip_pq_pkg::rank_t rank_d [OUT_DEPTH];
	skip_pq_pkg::meta_t meta_d [OUT_DEPTH];
	skip_pq_pkg::rank_t ins_rank;
	skip_pq_pkg::meta_t ins_meta;
	logic [CW-1:0] cnt_q;
	logic [CW-1:0] pop_cnt;
	logic [CW-1:0] cnt_d;
	logic [CW-1:0] pos;
	logic full;
	logic ins_ok;
	logic rem_ok;
	logic keep_new;
	logic evict;
	logic forward;
	logic do_ins;

	assign full = (cnt_q == CW'(OUT_DEPTH));
	assign ins_ok = insert && !busy && (num_entries < NW'(CAPACITY));
	assign rem_ok = remove && valid_out;

	// Routing of an accepted insert
	assign keep_new = ins_ok && ((list_empty && !full) ||
		(full && (rank_in < rank_q[OUT_DEPTH-1])));
	assign evict = keep_new && full;
	assign forward = ins_ok && !keep_new;

	always_comb
	begin
		// Pop first, then place the kept insert or the refill entry
		pop_cnt = cnt_q;
		for (int i = 0; i < OUT_DEPTH; i++)
		begin
			pop_rank[i] = rank_q[i];
			pop_meta[i] = meta_q[i];
		end
		if (rem_ok)
		begin
			pop_cnt = cnt_q - 1'b1;
			for (int i = 0; i < OUT_DEPTH - 1; i++)
			begin
				pop_rank[i] = rank_q[i+1];
				pop_meta[i] = meta_q[i+1];
			end
		end

		do_ins = keep_new || deq_valid;
		ins_rank = keep_new ? rank_in : deq_rank;
		ins_meta = keep_new ? meta_in : deq_meta;

		// Equal ranks stay ahead of the newcomer
		pos = '0;
		for (int i = 0; i < OUT_DEPTH; i++)
		begin
			if ((CW'(i) < pop_cnt) && (pop_rank[i] <= ins_rank))
			begin
				pos = CW'(i + 1);
			end
		end

		rank_d[0] = (do_ins && pos == '0) ? ins_rank : pop_rank[0];
		meta_d[0] = (do_ins && pos == '0) ? ins_meta : pop_meta[0];
		for (int i = 1; i < OUT_DEPTH; i++)
		begin
			if (!do_ins || CW'(i) < pos)
			begin
				rank_d[i] = pop_rank[i];
				meta_d[i] = pop_meta[i];
			end
			else if (CW'(i) == pos)
			begin
				rank_d[i] = ins_rank;
				meta_d[i] = ins_meta;
			end
			else
			begin
				rank_d[i] = pop_rank[i-1];
				meta_d[i] = pop_meta[i-1];
			end
		end

		// An eviction drops the old maximum off the end
		cnt_d = pop_cnt + CW'(do_ins && !evict);
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cnt_q <= '0;
			push_valid <= 1'b0;
			num_entries <= '0;
		end
		else
		begin
			cnt_q <= cnt_d;
			push_valid <= forward || evict;
			if (ins_ok)
			begin
				num_entries <= num_entries + 1'b1;
			end
			else if (rem_ok)
			begin
				num_entries <= num_entries - 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		rank_q <= rank_d;
		meta_q <= meta_d;
		push_rank <= evict ? rank_q[OUT_DEPTH-1] : rank_in;
		push_meta <= evict ? meta_q[OUT_DEPTH-1] : meta_in;
	end

	assign rank_out = rank_q[0];
	assign meta_out = meta_q[0];
	// Held low while a refill from the list is still owed
	assign valid_out = (cnt_q != '0) && (full || list_empty);
	assign has_room = !full;

endmodule

`default_nettype wire

// File: hdl/list_engine.sv
`default_nettype none

module list_engine #(
	parameter int L2_NODES = skip_pq_pkg::DEF_L2_NODES
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic push_valid,
	input wire skip_pq_pkg::rank_t push_rank,
	input wire skip_pq_pkg::meta_t push_meta,
	input wire logic has_room,
	output logic deq_valid,
	output skip_pq_pkg::rank_t deq_rank,
	output skip_pq_pkg::meta_t deq_meta,
	output logic list_empty,
	output logic busy
);

	typedef logic [L2_NODES-1:0] idx_t;

	localparam int NODES = 2 ** L2_NODES;
	localparam idx_t NIL = '1;
	localparam idx_t HEAD = idx_t'(0);
	localparam idx_t TAIL = idx_t'(1);

	typedef enum logic [3:0] {
		S_INIT_HEAD,
		S_INIT_TAIL,
		S_INIT_FILL,
		S_IDLE,
		S_WALK_WAIT,
		S_WALK_CMP,
		S_LINK_NEW,
		S_LINK_NBR,
		S_DQ_WAIT1,
		S_DQ_LPTR,
		S_DQ_WAIT2,
		S_DQ_EMIT
	} state_t;

	state_t state;
	idx_t rd_node;
	idx_t left_node;
	idx_t right_node;
	idx_t fill_node;
	skip_pq_pkg::rank_t new_rank;
	skip_pq_pkg::meta_t new_meta;
	logic [L2_NODES:0] list_cnt;
	logic start_dq;
	logic walk_on;

	// Node memory ports, rank and meta always share an address
	logic data_we;
	idx_t data_wa;
	skip_pq_pkg::rank_t rank_wd;
	skip_pq_pkg::rank_t rank_rd;
	skip_pq_pkg::meta_t meta_wd;
	skip_pq_pkg::meta_t meta_rd;
	logic rptr_we;
	idx_t rptr_wa;
	idx_t rptr_wd;
	idx_t rptr_rd;
	logic lptr_we;
	idx_t lptr_wa;
	idx_t lptr_wd;
	idx_t lptr_rd;

	logic fl_push;
	logic fl_pop;
	logic fl_empty;
	idx_t fl_push_node;
	idx_t fl_head;

	node_ram #(.T(skip_pq_pkg::rank_t), .L2_DEPTH(L2_NODES)) rank_ram (
		.clk(clk), .wr_en(data_we), .wr_addr(data_wa), .wr_data(rank_wd),
		.rd_addr(rd_node), .rd_data(rank_rd)
	);

	node_ram #(.T(skip_pq_pkg::meta_t), .L2_DEPTH(L2_NODES)) meta_ram (
		.clk(clk), .wr_en(data_we), .wr_addr(data_wa), .wr_data(meta_wd),
		.rd_addr(rd_node), .rd_data(meta_rd)
	);

	node_ram #(.T(idx_t), .L2_DEPTH(L2_NODES)) rptr_ram (
		.clk(clk), .wr_en(rptr_we), .wr_addr(rptr_wa), .wr_data(rptr_wd),
		.rd_addr(rd_node), .rd_data(rptr_rd)
	);

	node_ram #(.T(idx_t), .L2_DEPTH(L2_NODES)) lptr_ram (
		.clk(clk), .wr_en(lptr_we), .wr_addr(lptr_wa), .wr_data(lptr_wd),
		.rd_addr(rd_node), .rd_data(lptr_rd)
	);

	free_list #(.L2_NODES(L2_NODES)) node_free_list (
		.clk(clk), .rst(rst), .push(fl_push), .pop(fl_pop),
		.push_node(fl_push_node), .head_node(fl_head), .empty(fl_empty)
	);

	// Head is always a left candidate, the tail never passes the test
	assign walk_on = (rd_node == HEAD) || (rank_rd > new_rank);
	assign list_empty = (list_cnt == '0);
	assign start_dq = (state == S_IDLE) && !push_valid && has_room && !list_empty;
	assign busy = (state != S_IDLE) || push_valid || start_dq;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= S_INIT_HEAD;
			fill_node <= idx_t'(2);
			list_cnt <= '0;
		end
		else
		begin
			case (state)
				S_INIT_HEAD: state <= S_INIT_TAIL;
				S_INIT_TAIL: state <= S_INIT_FILL;
				S_INIT_FILL:
				begin
					fill_node <= fill_node + 1'b1;
					if (fill_node == idx_t'(NODES - 1))
					begin
						state <= S_IDLE;
					end
				end
				S_IDLE:
				begin
					// A pending push wins over a refill
					if (push_valid)
					begin
						list_cnt <= list_cnt + 1'b1;
						state <= S_WALK_WAIT;
					end
					else if (start_dq)
					begin
						state <= S_DQ_WAIT1;
					end
				end
				S_WALK_WAIT: state <= S_WALK_CMP;
				S_WALK_CMP: state <= walk_on ? S_WALK_WAIT : S_LINK_NEW;
				S_LINK_NEW: state <= S_LINK_NBR;
				S_LINK_NBR: state <= S_IDLE;
				S_DQ_WAIT1: state <= S_DQ_LPTR;
				S_DQ_LPTR: state <= S_DQ_WAIT2;
				S_DQ_WAIT2: state <= S_DQ_EMIT;
				S_DQ_EMIT:
				begin
					list_cnt <= list_cnt - 1'b1;
					state <= S_IDLE;
				end
				default: state <= S_INIT_HEAD;
			endcase
		end
	end

	// Search and dequeue bookkeeping
	always_ff @(posedge clk)
	begin
		case (state)
			S_IDLE:
			begin
				new_rank <= push_rank;
				new_meta <= push_meta;
				rd_node <= push_valid ? HEAD : TAIL;
			end
			S_WALK_CMP:
			begin
				if (walk_on)
				begin
					left_node <= rd_node;
					right_node <= rptr_rd;
					rd_node <= rptr_rd;
				end
			end
			// Node left of the tail is the list minimum
			S_DQ_LPTR: rd_node <= lptr_rd;
			default: ;
		endcase
	end

	always_comb
	begin
		data_we = 1'b0;
		data_wa = fl_head;
		rank_wd = new_rank;
		meta_wd = new_meta;
		rptr_we = 1'b0;
		rptr_wa = left_node;
		rptr_wd = fl_head;
		lptr_we = 1'b0;
		lptr_wa = right_node;
		lptr_wd = fl_head;
		fl_push = 1'b0;
		fl_push_node = fill_node;
		case (state)
			S_INIT_HEAD:
			begin
				data_we = 1'b1;
				data_wa = HEAD;
				rank_wd = skip_pq_pkg::RANK_MAX;
				meta_wd = '0;
				rptr_we = 1'b1;
				rptr_wa = HEAD;
				rptr_wd = TAIL;
				lptr_we = 1'b1;
				lptr_wa = HEAD;
				lptr_wd = NIL;
			end
			S_INIT_TAIL:
			begin
				data_we = 1'b1;
				data_wa = TAIL;
				rank_wd = skip_pq_pkg::RANK_MIN;
				meta_wd = '0;
				rptr_we = 1'b1;
				rptr_wa = TAIL;
				rptr_wd = NIL;
				lptr_we = 1'b1;
				lptr_wa = TAIL;
				lptr_wd = HEAD;
			end
			S_INIT_FILL: fl_push = 1'b1;
			S_LINK_NEW:
			begin
				// Fresh node points at both neighbours
				data_we = 1'b1;
				rptr_we = 1'b1;
				rptr_wa = fl_head;
				rptr_wd = right_node;
				lptr_we = 1'b1;
				lptr_wa = fl_head;
				lptr_wd = left_node;
			end
			S_LINK_NBR:
			begin
				rptr_we = 1'b1;
				lptr_we = 1'b1;
			end
			S_DQ_EMIT:
			begin
				// Unlink the dequeued node and give it back
				rptr_we = 1'b1;
				rptr_wa = lptr_rd;
				rptr_wd = TAIL;
				lptr_we = 1'b1;
				lptr_wa = TAIL;
				lptr_wd = lptr_rd;
				fl_push = 1'b1;
				fl_push_node = rd_node;
			end
			default: ;
		endcase
	end

	assign fl_pop = (state == S_LINK_NBR) && !fl_empty;
	assign deq_valid = (state == S_DQ_EMIT);
	assign deq_rank = rank_rd;
	assign deq_meta = meta_rd;

endmodule

`default_nettype wire

// File: hdl/skip_pq_top.sv
`default_nettype none

module skip_pq_top #(
	parameter int L2_NODES = skip_pq_pkg::DEF_L2_NODES,
	parameter int OUT_DEPTH = skip_pq_pkg::DEF_OUT_DEPTH
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic insert,
	input wire logic remove,
	input wire skip_pq_pkg::rank_t rank_in,
	input wire skip_pq_pkg::meta_t meta_in,
	output skip_pq_pkg::rank_t rank_out,
	output skip_pq_pkg::meta_t meta_out,
	output logic valid_out,
	output logic busy,
	output logic [L2_NODES:0] num_entries
);

	// Register to engine
	logic push_valid;
	skip_pq_pkg::rank_t push_rank;
	skip_pq_pkg::meta_t push_meta;
	logic has_room;

	// Engine to register
	logic deq_valid;
	skip_pq_pkg::rank_t deq_rank;
	skip_pq_pkg::meta_t deq_meta;
	logic list_empty;

	sorted_out_reg #(
		.L2_NODES(L2_NODES),
		.OUT_DEPTH(OUT_DEPTH)
	) out_reg (
		.clk(clk), .rst(rst),
		.insert(insert), .remove(remove),
		.busy(busy), .list_empty(list_empty),
		.rank_in(rank_in), .meta_in(meta_in),
		.deq_valid(deq_valid), .deq_rank(deq_rank), .deq_meta(deq_meta),
		.rank_out(rank_out), .meta_out(meta_out), .valid_out(valid_out),
		.has_room(has_room),
		.push_valid(push_valid), .push_rank(push_rank), .push_meta(push_meta),
		.num_entries(num_entries)
	);

	list_engine #(
		.L2_NODES(L2_NODES)
	) engine (
		.clk(clk), .rst(rst),
		.push_valid(push_valid), .push_rank(push_rank), .push_meta(push_meta),
		.has_room(has_room),
		.deq_valid(deq_valid), .deq_rank(deq_rank), .deq_meta(deq_meta),
		.list_empty(list_empty),
		.busy(busy)
	);

endmodule

`default_nettype wire

// File: tb/tb_skip_pq.sv
`default_nettype none

module tb_skip_pq;

	localparam int CAPACITY = 2 ** skip_pq_pkg::DEF_L2_NODES - 2 + skip_pq_pkg::DEF_OUT_DEPTH;
	localparam int COUNT_W = skip_pq_pkg::DEF_L2_NODES + 1;
	localparam int ENTRY_W = skip_pq_pkg::RANK_WIDTH + skip_pq_pkg::META_WIDTH;
	localparam int INIT_LIMIT = 200;
	localparam int WAIT_LIMIT = 200;
	localparam int RANDOM_STEPS = 200;

	logic clk;
	logic rst;
	logic insert;
	logic remove;
	skip_pq_pkg::rank_t rank_in;
	skip_pq_pkg::meta_t meta_in;
	skip_pq_pkg::rank_t rank_out;
	skip_pq_pkg::meta_t meta_out;
	logic valid_out;
	logic busy;
	logic [COUNT_W-1:0] num_entries;

	// Reference model of the queue contents
	skip_pq_pkg::rank_t model_rank [$];
	skip_pq_pkg::meta_t model_meta [$];
	skip_pq_pkg::rank_t exp_rank;
	skip_pq_pkg::meta_t exp_meta;
	event check_ev;
	int seed;
	int next_k;
	int errors;
	int mismatches;
	logic aborted;
	logic [31:0] coin;

	skip_pq_top uut (
		.clk(clk), .rst(rst),
		.insert(insert), .remove(remove),
		.rank_in(rank_in), .meta_in(meta_in),
		.rank_out(rank_out), .meta_out(meta_out), .valid_out(valid_out),
		.busy(busy), .num_entries(num_entries)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// 373 is coprime with the prime 1021, so every k gets its own rank
	function automatic skip_pq_pkg::rank_t perm_rank(input int k);
		return skip_pq_pkg::rank_t'(((k * 373) % 1021) + 1);
	endfunction

	// Smallest rank in the model packed with its meta
	function automatic logic [ENTRY_W-1:0] min_entry();
		int best;
		best = 0;
		for (int i = 1; i < model_rank.size(); i++)
		begin
			if (model_rank[i] < model_rank[best])
			begin
				best = i;
			end
		end
		return {model_rank[best], model_meta[best]};
	endfunction

	function automatic void drop_rank(input skip_pq_pkg::rank_t r);
		for (int i = 0; i < model_rank.size(); i++)
		begin
			if (model_rank[i] == r)
			begin
				model_rank.delete(i);
				model_meta.delete(i);
				break;
			end
		end
	endfunction

	// Compares the offered entry when a remove is strobed
	always @(check_ev)
	begin
		if (rank_out !== exp_rank)
		begin
			$display("Error at %0t: rank_out = %0d, expected %0d", $time, rank_out, exp_rank);
			mismatches++;
		end
		if (meta_out !== exp_meta)
		begin
			$display("Error at %0t: meta_out = %h, expected %h", $time, meta_out, exp_meta);
			mismatches++;
		end
	end

	task automatic check_count();
		if (num_entries !== COUNT_W'(model_rank.size()))
		begin
			$display("Error at %0t: num_entries = %0d, expected %0d",
				$time, num_entries, model_rank.size());
			mismatches++;
		end
	endtask

	task automatic check_invalid();
		if (valid_out !== 1'b0)
		begin
			$display("Error at %0t: valid_out = %b, expected 0", $time, valid_out);
			mismatches++;
		end
	endtask

	task automatic wait_idle(input int limit);
		int cycles;
		cycles = 0;
		while (busy && !aborted)
		begin
			if (cycles == limit)
			begin
				$display("Timeout at %0t: busy stayed high for %0d cycles", $time, limit);
				errors++;
				aborted = 1'b1;
			end
			else
			begin
				@(negedge clk);
				cycles++;
			end
		end
	endtask

	task automatic wait_valid(input int limit);
		int cycles;
		cycles = 0;
		while (!valid_out && !aborted)
		begin
			if (cycles == limit)
			begin
				$display("Timeout at %0t: valid_out stayed low for %0d cycles", $time, limit);
				errors++;
				aborted = 1'b1;
			end
			else
			begin
				@(negedge clk);
				cycles++;
			end
		end
	endtask

	task automatic do_insert();
		skip_pq_pkg::rank_t r;
		skip_pq_pkg::meta_t m;
		r = perm_rank(next_k);
		m = skip_pq_pkg::meta_t'($random(seed));
		next_k++;
		wait_idle(WAIT_LIMIT);
		if (!aborted)
		begin
			rank_in = r;
			meta_in = m;
			insert = 1'b1;
			// Taken only below capacity
			if (model_rank.size() < CAPACITY)
			begin
				model_rank.push_back(r);
				model_meta.push_back(m);
			end
			@(negedge clk);
			insert = 1'b0;
			check_count();
		end
	endtask

	task automatic do_remove();
		logic [ENTRY_W-1:0] entry;
		wait_valid(WAIT_LIMIT);
		if (!aborted)
		begin
			entry = min_entry();
			exp_rank = entry[ENTRY_W-1:skip_pq_pkg::META_WIDTH];
			exp_meta = entry[skip_pq_pkg::META_WIDTH-1:0];
			drop_rank(exp_rank);
			remove = 1'b1;
			-> check_ev;
			@(negedge clk);
			remove = 1'b0;
			check_count();
		end
	endtask

	initial
	begin
		seed = 49;
		next_k = 0;
		errors = 0;
		mismatches = 0;
		aborted = 1'b0;
		rst = 1'b1;
		insert = 1'b0;
		remove = 1'b0;
		rank_in = '0;
		meta_in = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// Reset state, then wait out the free list fill
		check_invalid();
		check_count();
		if (busy !== 1'b1)
		begin
			$display("Error at %0t: busy = %b, expected 1", $time, busy);
			mismatches++;
		end
		wait_idle(INIT_LIMIT);

		// Short fill that stays in the front register
		repeat (3) do_insert();
		while (model_rank.size() > 0 && !aborted)
		begin
			do_remove();
		end
		check_invalid();

		// Fill to capacity, one insert beyond it, then drain
		repeat (CAPACITY) do_insert();
		do_insert();
		while (model_rank.size() > 0 && !aborted)
		begin
			do_remove();
		end
		check_invalid();

		// Random mix of inserts and removes
		for (int step = 0; step < RANDOM_STEPS && !aborted; step++)
		begin
			coin = $random(seed);
			if (model_rank.size() == 0)
			begin
				do_insert();
			end
			else if (model_rank.size() == CAPACITY || coin[0])
			begin
				do_remove();
			end
			else
			begin
				do_insert();
			end
		end
		while (model_rank.size() > 0 && !aborted)
		begin
			do_remove();
		end

		// Remove on an empty queue is ignored
		remove = 1'b1;
		@(negedge clk);
		remove = 1'b0;
		check_count();
		check_invalid();
		do_insert();
		do_remove();
		check_invalid();

		$display("Done: %0d errors, %0d mismatches", errors, mismatches);
		if (errors == 0 && mismatches == 0)
		begin
			$display("STATUS: PASS");
		end
		else
		begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: skip_pq.f
hdl/skip_pq_pkg.sv
hdl/node_ram.sv
hdl/free_list.sv
hdl/sorted_out_reg.sv
hdl/list_engine.sv
hdl/skip_pq_top.sv
tb/tb_skip_pq.sv

// File: Bender.yml
package:
  name: skip_pq

sources:
  - files:
      - hdl/skip_pq_pkg.sv
      - hdl/node_ram.sv
      - hdl/free_list.sv
      - hdl/sorted_out_reg.sv
      - hdl/list_engine.sv
      - hdl/skip_pq_top.sv
  - target: test
    files:
      - tb/tb_skip_pq.sv
